//--- smartnic_lite_pkg.sv
`default_nettype none

package smartnic_lite_pkg;

    // ======================================================================
    // Port numbering
    // ======================================================================

    // Ingress and egress share one numbering, 0/1 line side and 2/3 host side
    localparam int NUM_PORTS = 4;

    typedef logic [1:0] port_t;

    // ======================================================================
    // Register map
    // ======================================================================

    localparam int REG_ADDR_W = 4;
    localparam int REG_DATA_W = 32;

    // Override enables in the low nibble, four 2-bit destinations above
    localparam logic [REG_ADDR_W-1:0] ADDR_OVERRIDE = 4'd0;
    localparam int OVR_EN_LSB   = 0;
    localparam int OVR_DEST_LSB = 4;

    // Egress enable mask
    localparam logic [REG_ADDR_W-1:0] ADDR_EGR_ENABLE = 4'd1;

    // Drop counters of ingress 0..3 at consecutive addresses, read only
    localparam logic [REG_ADDR_W-1:0] ADDR_DROP_BASE = 4'd2;

    localparam int DROP_CNT_W = 16;

    // ======================================================================
    // Reset values
    // ======================================================================

    localparam logic [REG_DATA_W-1:0] OVERRIDE_RST = '0;

    // Every egress port starts enabled
    localparam logic [NUM_PORTS-1:0] EGR_ENABLE_RST = '1;

endpackage

`default_nettype wire

//--- axis_if.sv
`timescale 1ns/1ns
`default_nettype none

// Packet stream between blocks of the switch
interface axis_if #(
    parameter int DATA_BYTE_WID = 8
);

    logic                          tvalid;
    logic                          tready;
    logic [DATA_BYTE_WID*8-1:0]    tdata;
    logic [DATA_BYTE_WID-1:0]      tkeep;
    logic                          tlast;
    smartnic_lite_pkg::port_t      tid;
    smartnic_lite_pkg::port_t      tdest;

    // Transmitting side
    modport source (
        output tvalid, tdata, tkeep, tlast, tid, tdest,
        input  tready
    );

    // Receiving side
    modport sink (
        input  tvalid, tdata, tkeep, tlast, tid, tdest,
        output tready
    );

endinterface

`default_nettype wire

//--- switch_regs.sv
`timescale 1ns/1ns
`default_nettype none

module switch_regs (
    input  logic                                        clk,
    input  logic                                        rst_n,
    input  logic                                        reg_wr_en,
    input  logic                                        reg_rd_en,
    input  logic [smartnic_lite_pkg::REG_ADDR_W-1:0]    reg_addr,
    input  logic [smartnic_lite_pkg::REG_DATA_W-1:0]    reg_wr_data,
    output logic [smartnic_lite_pkg::REG_DATA_W-1:0]    reg_rd_data,
    output logic [smartnic_lite_pkg::NUM_PORTS-1:0]     override_en,
    output smartnic_lite_pkg::port_t [smartnic_lite_pkg::NUM_PORTS-1:0] override_dest,
    output logic [smartnic_lite_pkg::NUM_PORTS-1:0]     egr_enable,
    input  logic [smartnic_lite_pkg::NUM_PORTS-1:0]     drop_pulse
);

    logic [smartnic_lite_pkg::DROP_CNT_W-1:0] drop_cnt [smartnic_lite_pkg::NUM_PORTS];

    logic [smartnic_lite_pkg::REG_ADDR_W-1:0] cnt_offset;
    logic                                     cnt_hit;
    logic [smartnic_lite_pkg::REG_DATA_W-1:0] rd_mux;

    // ======================================================================
    // Configuration registers
    // ======================================================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            override_en   <= smartnic_lite_pkg::OVERRIDE_RST[
                                 smartnic_lite_pkg::OVR_EN_LSB +: smartnic_lite_pkg::NUM_PORTS];
            override_dest <= smartnic_lite_pkg::OVERRIDE_RST[
                                 smartnic_lite_pkg::OVR_DEST_LSB +: $bits(override_dest)];
            egr_enable    <= smartnic_lite_pkg::EGR_ENABLE_RST;
        end else if (reg_wr_en) begin
            // Counter addresses fall through and are not writable
            if (reg_addr == smartnic_lite_pkg::ADDR_OVERRIDE) begin
                override_en   <= reg_wr_data[
                                     smartnic_lite_pkg::OVR_EN_LSB +: smartnic_lite_pkg::NUM_PORTS];
                override_dest <= reg_wr_data[
                                     smartnic_lite_pkg::OVR_DEST_LSB +: $bits(override_dest)];
            end else if (reg_addr == smartnic_lite_pkg::ADDR_EGR_ENABLE) begin
                egr_enable <= reg_wr_data[smartnic_lite_pkg::NUM_PORTS-1:0];
            end
        end
    end

    // ======================================================================
    // Drop counters
    // ======================================================================

    // Saturate at all ones
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < smartnic_lite_pkg::NUM_PORTS; i++) begin
                drop_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < smartnic_lite_pkg::NUM_PORTS; i++) begin
                if (drop_pulse[i] && (drop_cnt[i] != '1)) begin
                    drop_cnt[i] <= drop_cnt[i] + 1'b1;
                end
            end
        end
    end

    // ======================================================================
    // Read path
    // ======================================================================

    assign cnt_offset = reg_addr - smartnic_lite_pkg::ADDR_DROP_BASE;
    assign cnt_hit    = (reg_addr >= smartnic_lite_pkg::ADDR_DROP_BASE) &&
                        (cnt_offset < smartnic_lite_pkg::NUM_PORTS);

    always_comb begin
        rd_mux = '0;
        if (reg_addr == smartnic_lite_pkg::ADDR_OVERRIDE) begin
            rd_mux[smartnic_lite_pkg::OVR_EN_LSB +: smartnic_lite_pkg::NUM_PORTS] = override_en;
            rd_mux[smartnic_lite_pkg::OVR_DEST_LSB +: $bits(override_dest)]      = override_dest;
        end else if (reg_addr == smartnic_lite_pkg::ADDR_EGR_ENABLE) begin
            rd_mux[smartnic_lite_pkg::NUM_PORTS-1:0] = egr_enable;
        end else if (cnt_hit) begin
            rd_mux[smartnic_lite_pkg::DROP_CNT_W-1:0] =
                drop_cnt[smartnic_lite_pkg::port_t'(cnt_offset)];
        end
    end

    // Data lands one cycle after the strobe and holds until the next read
    always_ff @(posedge clk) begin
        if (reg_rd_en) begin
            reg_rd_data <= rd_mux;
        end
    end

endmodule

`default_nettype wire

//--- igr_router.sv
`timescale 1ns/1ns
`default_nettype none

module igr_router #(
    parameter int DATA_BYTE_WID = 8
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  smartnic_lite_pkg::port_t                port_id,
    axis_if.sink                                    axis_in,
    axis_if.source                                  axis_out,
    input  logic                                    override_en,
    input  smartnic_lite_pkg::port_t                override_dest,
    input  logic [smartnic_lite_pkg::NUM_PORTS-1:0] egr_enable,
    output logic                                    drop_pulse
);

    logic                       in_pkt;
    smartnic_lite_pkg::port_t   hold_dest;
    logic                       hold_drop;

    smartnic_lite_pkg::port_t   first_dest;
    logic                       first_drop;
    smartnic_lite_pkg::port_t   cur_dest;
    logic                       cur_drop;
    logic                       xfer;

    logic [DATA_BYTE_WID*8-1:0] beat_data;
    logic [DATA_BYTE_WID-1:0]   beat_keep;

    // ======================================================================
    // Destination decision
    // ======================================================================

    // Resolved from the head beat; the override wins over tdest
    assign first_dest = override_en ? override_dest : axis_in.tdest;
    assign first_drop = !egr_enable[first_dest];

    // Held values take over once the head beat has been seen
    assign cur_dest = in_pkt ? hold_dest : first_dest;
    assign cur_drop = in_pkt ? hold_drop : first_drop;

    // Freeze the decision on the first valid cycle, not the first transfer,
    // so a stalled head beat cannot change its destination
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_pkt    <= 1'b0;
            hold_dest <= '0;
            hold_drop <= 1'b0;
        end else if (xfer && axis_in.tlast) begin
            in_pkt <= 1'b0;
        end else if (axis_in.tvalid && !in_pkt) begin
            in_pkt    <= 1'b1;
            hold_dest <= first_dest;
            hold_drop <= first_drop;
        end
    end

    // ======================================================================
    // Stream path
    // ======================================================================

    assign beat_data = axis_in.tdata;
    assign beat_keep = axis_in.tkeep;

    assign axis_out.tvalid = axis_in.tvalid && !cur_drop;
    assign axis_out.tdata  = beat_data;
    assign axis_out.tkeep  = beat_keep;
    assign axis_out.tlast  = axis_in.tlast;
    assign axis_out.tid    = port_id;
    assign axis_out.tdest  = cur_dest;

    // Dropped packets are sunk at full rate
    assign axis_in.tready = cur_drop || axis_out.tready;

    assign xfer = axis_in.tvalid && axis_in.tready;

    // One pulse per dropped packet, on its last beat
    assign drop_pulse = xfer && axis_in.tlast && cur_drop;

endmodule

`default_nettype wire

//--- egr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module egr_arbiter #(
    parameter int DATA_BYTE_WID = 8
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  smartnic_lite_pkg::port_t                port_id,
    axis_if.sink                                    req [smartnic_lite_pkg::NUM_PORTS],
    output logic [smartnic_lite_pkg::NUM_PORTS-1:0] grant,
    axis_if.source                                  axis_out
);

    // Flattened copies of the router streams, indexable by a variable
    logic [DATA_BYTE_WID*8-1:0]     req_tdata  [smartnic_lite_pkg::NUM_PORTS];
    logic [DATA_BYTE_WID-1:0]       req_tkeep  [smartnic_lite_pkg::NUM_PORTS];
    logic                           req_tlast  [smartnic_lite_pkg::NUM_PORTS];
    smartnic_lite_pkg::port_t       req_tid    [smartnic_lite_pkg::NUM_PORTS];
    logic [smartnic_lite_pkg::NUM_PORTS-1:0] req_hit;

    logic                           locked;
    smartnic_lite_pkg::port_t       owner;
    smartnic_lite_pkg::port_t       rr_ptr;

    smartnic_lite_pkg::port_t       pick;
    logic                           pick_ok;
    smartnic_lite_pkg::port_t       sel;
    logic                           pkt_done;

    for (genvar i = 0; i < smartnic_lite_pkg::NUM_PORTS; i++) begin : g_req
        assign req_tdata[i]  = req[i].tdata;
        assign req_tkeep[i]  = req[i].tkeep;
        assign req_tlast[i]  = req[i].tlast;
        assign req_tid[i]    = req[i].tid;
        // Only beats aimed at this egress count as requests
        assign req_hit[i]    = req[i].tvalid && (req[i].tdest == port_id);
    end

    // ======================================================================
    // Round-robin pick
    // ======================================================================

    // Search starts at the port after the last winner
    always_comb begin
        smartnic_lite_pkg::port_t idx;
        pick    = rr_ptr;
        pick_ok = 1'b0;
        for (int k = 0; k < smartnic_lite_pkg::NUM_PORTS; k++) begin
            idx = smartnic_lite_pkg::port_t'(rr_ptr + k);
            if (!pick_ok && req_hit[idx]) begin
                pick    = idx;
                pick_ok = 1'b1;
            end
        end
    end

    assign sel      = locked ? owner : pick;
    assign pkt_done = axis_out.tvalid && axis_out.tready && axis_out.tlast;

    // Lock on the pick even if the head beat stalls, so the output holds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            locked <= 1'b0;
            owner  <= '0;
            rr_ptr <= '0;
        end else if (pkt_done) begin
            locked <= 1'b0;
            rr_ptr <= sel + 1'b1;
        end else if (!locked && pick_ok) begin
            locked <= 1'b1;
            owner  <= pick;
        end
    end

    always_comb begin
        grant = '0;
        if (locked || pick_ok) begin
            grant[sel] = 1'b1;
        end
    end

    // ======================================================================
    // Output multiplexer
    // ======================================================================

    assign axis_out.tvalid = req_hit[sel];
    assign axis_out.tdata  = req_tdata[sel];
    assign axis_out.tkeep  = req_tkeep[sel];
    assign axis_out.tlast  = req_tlast[sel];
    assign axis_out.tid    = req_tid[sel];
    assign axis_out.tdest  = port_id;

endmodule

`default_nettype wire

//--- pkt_switch.sv
`timescale 1ns/1ns
`default_nettype none

module pkt_switch #(
    parameter int DATA_BYTE_WID = 8
) (
    input  logic                                        clk,
    input  logic                                        rst_n,

    // Register port
    input  logic                                        reg_wr_en,
    input  logic                                        reg_rd_en,
    input  logic [smartnic_lite_pkg::REG_ADDR_W-1:0]    reg_addr,
    input  logic [smartnic_lite_pkg::REG_DATA_W-1:0]    reg_wr_data,
    output logic [smartnic_lite_pkg::REG_DATA_W-1:0]    reg_rd_data,

    // Ingress, 0/1 line side and 2/3 host to card
    input  logic [smartnic_lite_pkg::NUM_PORTS-1:0]     in_tvalid,
    output logic [smartnic_lite_pkg::NUM_PORTS-1:0]     in_tready,
    input  logic [smartnic_lite_pkg::NUM_PORTS-1:0][DATA_BYTE_WID*8-1:0] in_tdata,
    input  logic [smartnic_lite_pkg::NUM_PORTS-1:0][DATA_BYTE_WID-1:0]   in_tkeep,
    input  logic [smartnic_lite_pkg::NUM_PORTS-1:0]     in_tlast,
    input  smartnic_lite_pkg::port_t [smartnic_lite_pkg::NUM_PORTS-1:0]  in_tdest,

    // Egress, 0/1 line side and 2/3 card to host
    output logic [smartnic_lite_pkg::NUM_PORTS-1:0]     out_tvalid,
    input  logic [smartnic_lite_pkg::NUM_PORTS-1:0]     out_tready,
    output logic [smartnic_lite_pkg::NUM_PORTS-1:0][DATA_BYTE_WID*8-1:0] out_tdata,
    output logic [smartnic_lite_pkg::NUM_PORTS-1:0][DATA_BYTE_WID-1:0]   out_tkeep,
    output logic [smartnic_lite_pkg::NUM_PORTS-1:0]     out_tlast,
    output smartnic_lite_pkg::port_t [smartnic_lite_pkg::NUM_PORTS-1:0]  out_tid
);

    axis_if #(.DATA_BYTE_WID(DATA_BYTE_WID)) in_if  [smartnic_lite_pkg::NUM_PORTS] ();
    axis_if #(.DATA_BYTE_WID(DATA_BYTE_WID)) rt_if  [smartnic_lite_pkg::NUM_PORTS] ();
    axis_if #(.DATA_BYTE_WID(DATA_BYTE_WID)) out_if [smartnic_lite_pkg::NUM_PORTS] ();

    logic [smartnic_lite_pkg::NUM_PORTS-1:0]    override_en;
    smartnic_lite_pkg::port_t [smartnic_lite_pkg::NUM_PORTS-1:0] override_dest;
    logic [smartnic_lite_pkg::NUM_PORTS-1:0]    egr_enable;
    logic [smartnic_lite_pkg::NUM_PORTS-1:0]    drop_pulse;

    // Row per arbiter, one grant bit per router
    logic [smartnic_lite_pkg::NUM_PORTS-1:0]    arb_grant [smartnic_lite_pkg::NUM_PORTS];

    switch_regs u_regs (
        .clk           (clk),
        .rst_n         (rst_n),
        .reg_wr_en     (reg_wr_en),
        .reg_rd_en     (reg_rd_en),
        .reg_addr      (reg_addr),
        .reg_wr_data   (reg_wr_data),
        .reg_rd_data   (reg_rd_data),
        .override_en   (override_en),
        .override_dest (override_dest),
        .egr_enable    (egr_enable),
        .drop_pulse    (drop_pulse)
    );

    // ======================================================================
    // Ingress routers
    // ======================================================================

    for (genvar i = 0; i < smartnic_lite_pkg::NUM_PORTS; i++) begin : g_igr
        assign in_if[i].tvalid = in_tvalid[i];
        assign in_if[i].tdata  = in_tdata[i];
        assign in_if[i].tkeep  = in_tkeep[i];
        assign in_if[i].tlast  = in_tlast[i];
        assign in_if[i].tdest  = in_tdest[i];
        // No tid on the ingress pins
        assign in_if[i].tid    = '0;
        assign in_tready[i]    = in_if[i].tready;

        igr_router #(.DATA_BYTE_WID(DATA_BYTE_WID)) u_router (
            .clk           (clk),
            .rst_n         (rst_n),
            .port_id       (smartnic_lite_pkg::port_t'(i)),
            .axis_in       (in_if[i]),
            .axis_out      (rt_if[i]),
            .override_en   (override_en[i]),
            .override_dest (override_dest[i]),
            .egr_enable    (egr_enable),
            .drop_pulse    (drop_pulse[i])
        );
    end

    // ======================================================================
    // Egress arbiters
    // ======================================================================

    for (genvar e = 0; e < smartnic_lite_pkg::NUM_PORTS; e++) begin : g_egr
        egr_arbiter #(.DATA_BYTE_WID(DATA_BYTE_WID)) u_arb (
            .clk      (clk),
            .rst_n    (rst_n),
            .port_id  (smartnic_lite_pkg::port_t'(e)),
            .req      (rt_if),
            .grant    (arb_grant[e]),
            .axis_out (out_if[e])
        );

        assign out_if[e].tready = out_tready[e];
        assign out_tvalid[e]    = out_if[e].tvalid;
        assign out_tdata[e]     = out_if[e].tdata;
        assign out_tkeep[e]     = out_if[e].tkeep;
        assign out_tlast[e]     = out_if[e].tlast;
        assign out_tid[e]       = out_if[e].tid;
    end

    // A router moves only when the egress that granted it is ready
    for (genvar j = 0; j < smartnic_lite_pkg::NUM_PORTS; j++) begin : g_ready
        logic [smartnic_lite_pkg::NUM_PORTS-1:0] granted_ready;

        for (genvar e = 0; e < smartnic_lite_pkg::NUM_PORTS; e++) begin : g_col
            assign granted_ready[e] = arb_grant[e][j] && out_tready[e];
        end

        assign rt_if[j].tready = |granted_ready;
    end

endmodule

`default_nettype wire

//--- pkt_switch_sva.sv
`timescale 1ns/1ns
`default_nettype none

module pkt_switch_sva #(
    parameter int DATA_BYTE_WID = 8
) (
    input logic                                                         clk,
    input logic                                                         rst_n,
    input logic [smartnic_lite_pkg::NUM_PORTS-1:0]                      out_tvalid,
    input logic [smartnic_lite_pkg::NUM_PORTS-1:0]                      out_tready,
    input logic [smartnic_lite_pkg::NUM_PORTS-1:0][DATA_BYTE_WID*8-1:0] out_tdata,
    input logic [smartnic_lite_pkg::NUM_PORTS-1:0]                      out_tlast,
    input smartnic_lite_pkg::port_t [smartnic_lite_pkg::NUM_PORTS-1:0]  out_tid
);

    for (genvar p = 0; p < smartnic_lite_pkg::NUM_PORTS; p++) begin : g_port
        logic                       mid_pkt;
        smartnic_lite_pkg::port_t   pkt_tid;

        // Track the owner of the packet in flight
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                mid_pkt <= 1'b0;
                pkt_tid <= '0;
            end else if (out_tvalid[p] && out_tready[p]) begin
                mid_pkt <= !out_tlast[p];
                pkt_tid <= out_tid[p];
            end
        end

        // A stalled beat keeps valid high and its payload unchanged
        a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
            out_tvalid[p] && !out_tready[p] |=>
                out_tvalid[p] && $stable(out_tdata[p]) && $stable(out_tlast[p]) &&
                $stable(out_tid[p]))
            else $error("egress %0d changed a stalled beat", p);

        a_tid_fixed: assert property (@(posedge clk) disable iff (!rst_n)
            mid_pkt && out_tvalid[p] |-> out_tid[p] == pkt_tid)
            else $error("egress %0d tid changed inside a packet", p);
    end

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> out_tvalid == '0)
        else $error("egress valid high during reset");

endmodule

bind pkt_switch pkt_switch_sva #(.DATA_BYTE_WID(DATA_BYTE_WID)) u_sva (
    .clk        (clk),
    .rst_n      (rst_n),
    .out_tvalid (out_tvalid),
    .out_tready (out_tready),
    .out_tdata  (out_tdata),
    .out_tlast  (out_tlast),
    .out_tid    (out_tid)
);

`default_nettype wire

//--- tb_pkt_switch.sv
`timescale 1ns/1ns
`default_nettype none

module tb_pkt_switch;

    localparam int DBW    = 8;
    localparam int DW     = DBW * 8;
    localparam int NP     = smartnic_lite_pkg::NUM_PORTS;
    localparam int BEAT_W = 1 + DBW + DW;
    localparam int PKTS   = 20;

    // Worst case every ingress queues behind one egress, 6 beats plus 3 idle
    // per packet, doubled for back-pressure, over four traffic tests
    localparam int EST_CYCLES     = 4 * (NP * PKTS * 9 * 2) + 500;
    localparam int TIMEOUT_CYCLES = 4 * EST_CYCLES;

    logic                                           clk;
    logic                                           rst_n;
    logic                                           reg_wr_en;
    logic                                           reg_rd_en;
    logic [smartnic_lite_pkg::REG_ADDR_W-1:0]       reg_addr;
    logic [smartnic_lite_pkg::REG_DATA_W-1:0]       reg_wr_data;
    logic [smartnic_lite_pkg::REG_DATA_W-1:0]       reg_rd_data;
    logic [NP-1:0]                                  in_tvalid;
    logic [NP-1:0]                                  in_tready;
    logic [NP-1:0][DW-1:0]                          in_tdata;
    logic [NP-1:0][DBW-1:0]                         in_tkeep;
    logic [NP-1:0]                                  in_tlast;
    smartnic_lite_pkg::port_t [NP-1:0]              in_tdest;
    logic [NP-1:0]                                  out_tvalid;
    logic [NP-1:0]                                  out_tready;
    logic [NP-1:0][DW-1:0]                          out_tdata;
    logic [NP-1:0][DBW-1:0]                         out_tkeep;
    logic [NP-1:0]                                  out_tlast;
    smartnic_lite_pkg::port_t [NP-1:0]              out_tid;

    // Reference model state
    logic [BEAT_W-1:0]          exp_q [NP][NP][$];
    logic [NP-1:0]              ovr_en_m;
    smartnic_lite_pkg::port_t   ovr_dest_m [NP];
    logic [NP-1:0]              egr_en_m;
    int                         drop_m [NP];

    // Monitor state per egress
    logic [NP-1:0]              mon_busy;
    int                         mon_tid [NP];

    bit  bp_en;
    int  errors;
    int  test_errors;
    int  test_num;
    int  pkts_sent;
    int  pkts_recv;
    int  pkts_drop;
    int  cycle_cnt;

    pkt_switch #(.DATA_BYTE_WID(DBW)) uut (
        .clk         (clk),
        .rst_n       (rst_n),
        .reg_wr_en   (reg_wr_en),
        .reg_rd_en   (reg_rd_en),
        .reg_addr    (reg_addr),
        .reg_wr_data (reg_wr_data),
        .reg_rd_data (reg_rd_data),
        .in_tvalid   (in_tvalid),
        .in_tready   (in_tready),
        .in_tdata    (in_tdata),
        .in_tkeep    (in_tkeep),
        .in_tlast    (in_tlast),
        .in_tdest    (in_tdest),
        .out_tvalid  (out_tvalid),
        .out_tready  (out_tready),
        .out_tdata   (out_tdata),
        .out_tkeep   (out_tkeep),
        .out_tlast   (out_tlast),
        .out_tid     (out_tid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TB FAILED");
        $finish;
    end

    // Egress ready, random while back-pressure is on
    initial begin
        forever begin
            @(posedge clk);
            #1;
            out_tready = bp_en ? NP'($urandom) : '1;
        end
    end

    // ======================================================================
    // Stimulus helpers
    // ======================================================================

    function automatic logic [DW-1:0] rand_data();
        logic [DW-1:0] d;
        for (int b = 0; b < DBW; b++) begin
            d[b*8 +: 8] = 8'($urandom);
        end
        return d;
    endfunction

    function automatic bit queues_empty();
        for (int e = 0; e < NP; e++) begin
            for (int i = 0; i < NP; i++) begin
                if (exp_q[e][i].size() != 0) begin
                    return 1'b0;
                end
            end
        end
        return 1'b1;
    endfunction

    task automatic reg_write(input logic [3:0] addr, input logic [31:0] data);
        reg_addr    = addr;
        reg_wr_data = data;
        reg_wr_en   = 1'b1;
        @(posedge clk);
        #1;
        reg_wr_en = 1'b0;
    endtask

    task automatic reg_read(input logic [3:0] addr, output logic [31:0] data);
        reg_addr  = addr;
        reg_rd_en = 1'b1;
        @(posedge clk);
        #1;
        reg_rd_en = 1'b0;
        data      = reg_rd_data;
    endtask

    // Enables in bits 3:0, 2-bit destinations from bit 4 up
    task automatic write_override(input logic [31:0] value);
        reg_write(smartnic_lite_pkg::ADDR_OVERRIDE, value);
        for (int i = 0; i < NP; i++) begin
            ovr_en_m[i]   = value[i];
            ovr_dest_m[i] = value[4 + 2*i +: 2];
        end
    endtask

    task automatic write_enable(input logic [NP-1:0] mask);
        reg_write(smartnic_lite_pkg::ADDR_EGR_ENABLE, 32'(mask));
        egr_en_m = mask;
    endtask

    // Random packets on one ingress, with the model fed at packet start
    task automatic drive_port(input int i, input int npkts);
        int                         nbeats;
        int                         gap;
        smartnic_lite_pkg::port_t   tdest;
        smartnic_lite_pkg::port_t   dest;
        logic [DW-1:0]              data;
        logic [DBW-1:0]             keep;
        logic                       last;
        bit                         drop;
        for (int p = 0; p < npkts; p++) begin
            nbeats = 1 + $urandom_range(5);
            tdest  = smartnic_lite_pkg::port_t'($urandom_range(NP - 1));
            dest   = ovr_en_m[i] ? ovr_dest_m[i] : tdest;
            drop   = !egr_en_m[dest];
            pkts_sent++;
            if (drop) begin
                drop_m[i]++;
                pkts_drop++;
            end
            for (int b = 0; b < nbeats; b++) begin
                data = rand_data();
                last = (b == nbeats - 1);
                keep = last ? DBW'($urandom_range(2**DBW - 1, 1)) : '1;
                if (!drop) begin
                    exp_q[dest][i].push_back({last, keep, data});
                end
                in_tvalid[i] = 1'b1;
                in_tdata[i]  = data;
                in_tkeep[i]  = keep;
                in_tlast[i]  = last;
                in_tdest[i]  = tdest;
                @(negedge clk);
                while (!in_tready[i]) begin
                    @(negedge clk);
                end
                @(posedge clk);
                #1;
            end
            in_tvalid[i] = 1'b0;
            gap = $urandom_range(3);
            for (int g = 0; g < gap; g++) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic run_traffic(input int npkts);
        fork
            drive_port(0, npkts);
            drive_port(1, npkts);
            drive_port(2, npkts);
            drive_port(3, npkts);
        join
        // Settle so the last drop pulses reach the counters
        repeat (4) @(posedge clk);
        #1;
        if (!queues_empty()) begin
            errors++;
            $display("Expected packets never arrived at their egress ports");
        end
    endtask

    task automatic end_test(input string name);
        test_num++;
        $display("test %0d %s: %s, %0d errors", test_num, name,
                 (errors == test_errors) ? "ok" : "failing", errors - test_errors);
        test_errors = errors;
    endtask

    task automatic check_drops();
        logic [31:0] rd;
        for (int i = 0; i < NP; i++) begin
            reg_read(smartnic_lite_pkg::ADDR_DROP_BASE + 4'(i), rd);
            if (rd !== 32'(drop_m[i])) begin
                errors++;
                $display("error %0t: drop counter %0d reads %0d, model %0d",
                         $time, i, rd, drop_m[i]);
            end
        end
    endtask

    // ======================================================================
    // Egress monitor
    // ======================================================================

    task automatic check_beat(input int e);
        logic [BEAT_W-1:0] got;
        logic [BEAT_W-1:0] exp;
        int                t;
        t   = out_tid[e];
        got = {out_tlast[e], out_tkeep[e], out_tdata[e]};
        if (mon_busy[e] && (t != mon_tid[e])) begin
            errors++;
            $display("error %0t: egress %0d interleaved ingress %0d into a packet of %0d",
                     $time, e, t, mon_tid[e]);
        end
        if (exp_q[e][t].size() == 0) begin
            errors++;
            $display("error %0t: egress %0d unexpected beat from ingress %0d", $time, e, t);
        end else begin
            exp = exp_q[e][t].pop_front();
            if (got !== exp) begin
                errors++;
                $display("error %0t: egress %0d from ingress %0d got %h, expected %h",
                         $time, e, t, got, exp);
            end
        end
        mon_busy[e] = !out_tlast[e];
        mon_tid[e]  = t;
        if (out_tlast[e]) begin
            pkts_recv++;
        end
    endtask

    // Inputs move 1 ns after the rising edge, so the falling edge sees a settled handshake
    always @(negedge clk) begin
        if (rst_n) begin
            for (int e = 0; e < NP; e++) begin
                if (out_tvalid[e] && out_tready[e]) begin
                    check_beat(e);
                end
            end
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        logic [31:0] rd;
        logic [31:0] val;
        void'($urandom(32'hf2a2e0e4));
        rst_n       = 1'b0;
        reg_wr_en   = 1'b0;
        reg_rd_en   = 1'b0;
        reg_addr    = '0;
        reg_wr_data = '0;
        in_tvalid   = '0;
        in_tdata    = '0;
        in_tkeep    = '0;
        in_tlast    = '0;
        in_tdest    = '0;
        out_tready  = '1;
        bp_en       = 1'b0;
        ovr_en_m    = '0;
        egr_en_m    = '1;
        mon_busy    = '0;
        for (int i = 0; i < NP; i++) begin
            ovr_dest_m[i] = '0;
            drop_m[i]     = 0;
            mon_tid[i]    = 0;
        end
        errors      = 0;
        test_errors = 0;
        test_num    = 0;
        pkts_sent   = 0;
        pkts_recv   = 0;
        pkts_drop   = 0;

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (2) @(posedge clk);
        #1;

        run_traffic(PKTS);
        end_test("routing by tdest");

        // Ingress 0 to port 3, ingress 2 to port 1
        write_override(32'h0000_0935);
        run_traffic(PKTS);
        end_test("override routing");

        write_override(32'h0);
        write_enable(4'b0101);
        run_traffic(PKTS);
        check_drops();
        end_test("egress disable");

        write_enable(4'b1111);
        bp_en = 1'b1;
        run_traffic(PKTS);
        bp_en = 1'b0;
        end_test("random back-pressure");

        val = 32'($urandom_range(12'hfff));
        write_override(val);
        reg_read(smartnic_lite_pkg::ADDR_OVERRIDE, rd);
        if (rd !== val) begin
            errors++;
            $display("error %0t: override reads %h, wrote %h", $time, rd, val);
        end
        val = 32'($urandom_range(4'hf));
        write_enable(val[NP-1:0]);
        reg_read(smartnic_lite_pkg::ADDR_EGR_ENABLE, rd);
        if (rd !== val) begin
            errors++;
            $display("error %0t: egress enable reads %h, wrote %h", $time, rd, val);
        end
        for (int i = 0; i < NP; i++) begin
            reg_write(smartnic_lite_pkg::ADDR_DROP_BASE + 4'(i), $urandom);
        end
        check_drops();
        end_test("register readback");

        $display("summary: %0d tests, %0d packets sent, %0d received, %0d dropped, %0d errors",
                 test_num, pkts_sent, pkts_recv, pkts_drop, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
smartnic_lite_pkg.sv
axis_if.sv
switch_regs.sv
igr_router.sv
egr_arbiter.sv
pkt_switch.sv
pkt_switch_sva.sv
tb_pkt_switch.sv
